//--- Makefile
# Verilator build for the system control block testbench

VERILATOR ?= verilator
TOP       ?= tb_sys_ctl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/idt_fetch.sv
`timescale 1ns/100ps

module idt_fetch (
  input  logic                           or_int_vec,
  input  logic                           arst_n,
  input  logic [sys_ctl_pkg::vec_w-1:0]  svc_vector,
  input  logic                           svc_sel,
  input  logic                           capture_lo,
  input  logic [sys_ctl_pkg::addr_w-1:0] mem_dp_read_data,
  output logic [sys_ctl_pkg::addr_w-1:0] mem_address,
  output sys_ctl_pkg::idt_target_t       svc_target
);
  import sys_ctl_pkg::*;

  logic [addr_w-1:0] entry_base;
  logic [addr_w-1:0] swapped;
  logic [addr_w-1:0] lo_word_q;

  //////////////////////////////////////////////////
  // table address

  assign entry_base  = idt_base_table[svc_vector];
  assign mem_address = svc_sel ? entry_base + idt_step : entry_base;

  //////////////////////////////////////////////////
  // read data

  // table words are stored big endian
  assign swapped = {
    mem_dp_read_data[7:0],
    mem_dp_read_data[15:8],
    mem_dp_read_data[23:16],
    mem_dp_read_data[31:24]
  };

  always_ff @(posedge or_int_vec or negedge arst_n) begin
    if (!arst_n) begin
      lo_word_q <= '0;
    end else if (capture_lo) begin
      lo_word_q <= swapped;
    end
  end

  // second word is live on the data beat that ends the service
  assign svc_target.cs  = swapped[addr_w-1:sel_w];
  assign svc_target.eip = {swapped[addr_w-1:sel_w], lo_word_q[sel_w-1:0]};

endmodule

//--- src/int_pending.sv
`timescale 1ns/100ps

module int_pending (
  input  logic                          or_int_vec,
  input  logic                          arst_n,
  input  logic [sys_ctl_pkg::num_int-1:0] int_vec,
  input  logic                          int_clear,
  output logic                          pending_int,
  output logic [sys_ctl_pkg::vec_w-1:0]  svc_vector
);
  import sys_ctl_pkg::*;

  logic [num_int-1:0] pend_q;
  logic [num_int-1:0] clear_mask;

  // lowest numbered pending line wins
  always_comb begin
    svc_vector = '0;
    for (int i = num_int - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        svc_vector = vec_w'(i);
      end
    end
  end

  always_comb begin
    clear_mask = '0;
    if (int_clear) begin
      clear_mask[svc_vector] = 1'b1;
    end
  end

  // new lines keep latching while a service is in flight
  always_ff @(posedge or_int_vec or negedge arst_n) begin
    if (!arst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q | int_vec) & ~clear_mask;
    end
  end

  assign pending_int = |pend_q;

endmodule

//--- src/redirect_merge.sv
`timescale 1ns/100ps

module redirect_merge (
  input  logic                           or_int_vec,
  input  logic                           arst_n,
  input  sys_ctl_pkg::jump_req_t         jump,
  input  logic                           svc_done,
  input  sys_ctl_pkg::idt_target_t       svc_target,
  input  sys_ctl_pkg::ret_step_t         ret_step,
  input  logic [sys_ctl_pkg::addr_w-1:0] iretd_pop_data,
  input  logic                           iretd_halt,
  output sys_ctl_pkg::flush_t            flush,
  output sys_ctl_pkg::fetch_redirect_t   fetch,
  output sys_ctl_pkg::arch_load_t        arch
);
  import sys_ctl_pkg::*;

  jump_req_t jump_q;
  logic      front_flush;

  always_ff @(posedge or_int_vec or negedge arst_n) begin
    if (!arst_n) begin
      jump_q <= '0;
    end else begin
      jump_q <= jump;
    end
  end

  //////////////////////////////////////////////////
  // flushes

  assign front_flush = jump_q.load || svc_done;

  assign flush.fetch     = front_flush || iretd_halt;
  assign flush.decode_0  = front_flush;
  assign flush.decode_1  = front_flush;
  assign flush.register  = front_flush;
  assign flush.address   = front_flush;
  assign flush.execute   = front_flush;
  assign flush.writeback = 1'b0;

  //////////////////////////////////////////////////
  // fetch redirect, jump then pop then interrupt

  assign fetch.load = jump_q.load || ret_step.eip || svc_done;

  always_comb begin
    if (jump_q.load) begin
      fetch.address = jump_q.address;
    end else if (ret_step.eip) begin
      fetch.address = iretd_pop_data;
    end else begin
      fetch.address = svc_target.eip;
    end
  end

  //////////////////////////////////////////////////
  // architectural loads

  assign arch.load_eflags = ret_step.eflags;
  assign arch.eflags      = iretd_pop_data;
  assign arch.load_eip    = ret_step.eip;
  assign arch.eip         = iretd_pop_data;
  assign arch.load_cs     = jump_q.load_cs || ret_step.cs || svc_done;

  always_comb begin
    if (jump_q.load_cs) begin
      arch.cs = jump_q.cs;
    end else if (ret_step.cs) begin
      arch.cs = iretd_pop_data[sel_w-1:0];
    end else begin
      arch.cs = svc_target.cs;
    end
  end

endmodule

//--- src/sys_ctl_fsm.sv
`timescale 1ns/100ps

module sys_ctl_fsm (
  input  logic                   or_int_vec,
  input  logic                   arst_n,
  input  logic                   pending_int,
  input  logic                   hold_int,
  input  logic                   mem_ready,
  input  logic                   mem_dp_valid,
  input  logic                   iretd,
  input  logic                   ret_far,
  input  logic                   ret_near,
  input  logic                   iretd_pop_valid,
  output logic                   mem_valid,
  output logic                   mem_dp_ready,
  output logic                   svc_sel,
  output logic                   capture_lo,
  output logic                   svc_done,
  output logic                   int_clear,
  output sys_ctl_pkg::ret_step_t ret_step,
  output logic                   iretd_halt
);
  import sys_ctl_pkg::*;

  ret_state_t ret_q;
  ret_state_t ret_d;
  logic       svc_busy_q;
  logic       svc_wait_q;
  logic       svc_sel_q;
  logic       idle;
  logic       ret_start;
  logic       svc_start;
  logic       pop_ok;
  logic       req_accept;
  logic       data_beat;

  //////////////////////////////////////////////////
  // arbitration

  assign idle      = (ret_q == st_idle) && !svc_busy_q;
  assign ret_start = idle && (iretd || ret_far || ret_near);
  // returns win over a pending interrupt in the same cycle
  assign svc_start = idle && !ret_start && pending_int && !hold_int;

  //////////////////////////////////////////////////
  // return pop sequence

  assign iretd_halt = (ret_q != st_idle);
  assign pop_ok     = iretd_halt && iretd_pop_valid;

  assign ret_step.eflags = pop_ok && (ret_q == st_eflags);
  assign ret_step.cs     = pop_ok && (ret_q == st_cs);
  assign ret_step.eip    = pop_ok && (ret_q == st_eip);

  always_comb begin
    ret_d = ret_q;
    if (ret_start) begin
      if (iretd) begin
        ret_d = st_eflags;
      end else if (ret_far) begin
        ret_d = st_cs;
      end else begin
        ret_d = st_eip;
      end
    end else if (pop_ok) begin
      case (ret_q)
        st_eflags: ret_d = st_cs;
        st_cs:     ret_d = st_eip;
        default:   ret_d = st_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // interrupt service reads

  // request phase while busy and not waiting, data phase after acceptance
  assign mem_valid    = svc_busy_q && !svc_wait_q;
  assign mem_dp_ready = svc_busy_q && svc_wait_q;
  assign req_accept   = mem_valid && mem_ready;
  assign data_beat    = mem_dp_ready && mem_dp_valid;

  assign svc_sel    = svc_sel_q;
  assign capture_lo = data_beat && !svc_sel_q;
  assign svc_done   = data_beat && svc_sel_q;
  assign int_clear  = svc_done;

  always_ff @(posedge or_int_vec or negedge arst_n) begin
    if (!arst_n) begin
      ret_q      <= st_idle;
      svc_busy_q <= 1'b0;
      svc_wait_q <= 1'b0;
      svc_sel_q  <= 1'b0;
    end else begin
      ret_q <= ret_d;
      if (svc_start) begin
        svc_busy_q <= 1'b1;
        svc_wait_q <= 1'b0;
        svc_sel_q  <= 1'b0;
      end else if (req_accept) begin
        svc_wait_q <= 1'b1;
      end else if (capture_lo) begin
        // first word in, go ask for the second
        svc_wait_q <= 1'b0;
        svc_sel_q  <= 1'b1;
      end else if (svc_done) begin
        svc_busy_q <= 1'b0;
        svc_wait_q <= 1'b0;
        svc_sel_q  <= 1'b0;
      end
    end
  end

endmodule

//--- src/sys_ctl_pkg.sv
package sys_ctl_pkg;

  localparam int addr_w  = 32;
  localparam int sel_w   = 16;
  localparam int num_int = 16;
  localparam int vec_w   = 4;

  // descriptor table base per interrupt line
  localparam logic [addr_w-1:0] idt_base_table [num_int] = '{
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_f000, 32'h0000_f000, 32'h0000_f000, 32'h0000_f000,
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_0100, 32'h0000_f000, 32'h0000_f000, 32'h0000_f000
  };

  // second descriptor word sits one word above the base
  localparam logic [addr_w-1:0] idt_step = 32'd4;

  typedef enum logic [1:0] {
    st_idle,
    st_eflags,
    st_cs,
    st_eip
  } ret_state_t;

  typedef struct packed {
    logic fetch;
    logic decode_0;
    logic decode_1;
    logic register;
    logic address;
    logic execute;
    logic writeback;
  } flush_t;

  typedef struct packed {
    logic              load;
    logic [addr_w-1:0] address;
  } fetch_redirect_t;

  typedef struct packed {
    logic              load_eflags;
    logic [addr_w-1:0] eflags;
    logic              load_cs;
    logic [sel_w-1:0]  cs;
    logic              load_eip;
    logic [addr_w-1:0] eip;
  } arch_load_t;

  typedef struct packed {
    logic              load;
    logic [addr_w-1:0] address;
    logic              load_cs;
    logic [sel_w-1:0]  cs;
  } jump_req_t;

  typedef struct packed {
    logic [sel_w-1:0]  cs;
    logic [addr_w-1:0] eip;
  } idt_target_t;

  // one-hot mark of the pop consumed this cycle
  typedef struct packed {
    logic eflags;
    logic cs;
    logic eip;
  } ret_step_t;

endpackage

//--- src/sys_ctl_top.sv
`timescale 1ns/100ps

module sys_ctl_top (
  input  logic                            or_int_vec,
  input  logic                            arst_n,
  input  logic [sys_ctl_pkg::num_int-1:0] int_vec,
  input  logic                            hold_int,
  output logic                            mem_valid,
  input  logic                            mem_ready,
  output logic [sys_ctl_pkg::addr_w-1:0]  mem_address,
  input  logic                            mem_dp_valid,
  output logic                            mem_dp_ready,
  input  logic [sys_ctl_pkg::addr_w-1:0]  mem_dp_read_data,
  input  logic                            iretd,
  input  logic                            ret_far,
  input  logic                            ret_near,
  input  logic                            iretd_pop_valid,
  input  logic [sys_ctl_pkg::addr_w-1:0]  iretd_pop_data,
  input  sys_ctl_pkg::jump_req_t          jump,
  output logic                            pending_int,
  output logic                            iretd_halt,
  output sys_ctl_pkg::flush_t             flush,
  output sys_ctl_pkg::fetch_redirect_t    fetch,
  output sys_ctl_pkg::arch_load_t         arch
);
  import sys_ctl_pkg::*;

  logic              svc_sel;
  logic              capture_lo;
  logic              svc_done;
  logic              int_clear;
  logic [vec_w-1:0]  svc_vector;
  ret_step_t         ret_step;
  idt_target_t       svc_target;

  int_pending int_pending_i (
    .or_int_vec  (or_int_vec),
    .arst_n      (arst_n),
    .int_vec     (int_vec),
    .int_clear   (int_clear),
    .pending_int (pending_int),
    .svc_vector  (svc_vector)
  );

  idt_fetch idt_fetch_i (
    .or_int_vec       (or_int_vec),
    .arst_n           (arst_n),
    .svc_vector       (svc_vector),
    .svc_sel          (svc_sel),
    .capture_lo       (capture_lo),
    .mem_dp_read_data (mem_dp_read_data),
    .mem_address      (mem_address),
    .svc_target       (svc_target)
  );

  sys_ctl_fsm sys_ctl_fsm_i (
    .or_int_vec      (or_int_vec),
    .arst_n          (arst_n),
    .pending_int     (pending_int),
    .hold_int        (hold_int),
    .mem_ready       (mem_ready),
    .mem_dp_valid    (mem_dp_valid),
    .iretd           (iretd),
    .ret_far         (ret_far),
    .ret_near        (ret_near),
    .iretd_pop_valid (iretd_pop_valid),
    .mem_valid       (mem_valid),
    .mem_dp_ready    (mem_dp_ready),
    .svc_sel         (svc_sel),
    .capture_lo      (capture_lo),
    .svc_done        (svc_done),
    .int_clear       (int_clear),
    .ret_step        (ret_step),
    .iretd_halt      (iretd_halt)
  );

  redirect_merge redirect_merge_i (
    .or_int_vec     (or_int_vec),
    .arst_n         (arst_n),
    .jump           (jump),
    .svc_done       (svc_done),
    .svc_target     (svc_target),
    .ret_step       (ret_step),
    .iretd_pop_data (iretd_pop_data),
    .iretd_halt     (iretd_halt),
    .flush          (flush),
    .fetch          (fetch),
    .arch           (arch)
  );

endmodule

//--- tb/sys_ctl_asserts.sv
`timescale 1ns/100ps

module sys_ctl_asserts (
  input logic                         or_int_vec,
  input logic                         arst_n,
  input logic                         mem_valid,
  input logic                         mem_ready,
  input logic                         iretd_halt,
  input sys_ctl_pkg::flush_t          flush,
  input sys_ctl_pkg::fetch_redirect_t fetch
);

  // request stays up until the memory takes it
  req_hold: assert property (@(posedge or_int_vec) disable iff (!arst_n)
    mem_valid && !mem_ready |=> mem_valid)
    else $error("mem_valid dropped before mem_ready");

  halt_flushes_fetch: assert property (@(posedge or_int_vec) disable iff (!arst_n)
    iretd_halt |-> flush.fetch)
    else $error("iretd_halt without flush.fetch");

  // table reads and return pops never overlap
  no_read_in_return: assert property (@(posedge or_int_vec) disable iff (!arst_n)
    !(mem_valid && iretd_halt))
    else $error("mem_valid high during a return");

  load_single_cycle: assert property (@(posedge or_int_vec) disable iff (!arst_n)
    fetch.load && !iretd_halt |=> !fetch.load)
    else $error("fetch.load held longer than one cycle");

endmodule

bind sys_ctl_top sys_ctl_asserts sys_ctl_asserts_i (
  .or_int_vec (or_int_vec),
  .arst_n     (arst_n),
  .mem_valid  (mem_valid),
  .mem_ready  (mem_ready),
  .iretd_halt (iretd_halt),
  .flush      (flush),
  .fetch      (fetch)
);

//--- tb/sys_ctl_patterns.txt
// kind a0 a1 a2 a3 e0 e1 e2 e3 flags, one scenario per line, all hex
// 1 jump, 2 interrupt (a3 hold cycles), 3 line pair, 4 far ret, 5 near ret, 6 iretd, 0 end
1 00012340 1 0008 0 00012340 0008 0 0 17e
1 0badf00c 0 0010 0 0badf00c 0 0 0 07e
2 0 78563412 efcdab89 0 00004000 89ab5678 89ab 0 17e
2 3 11223344 aabbccdd 0 0000f000 ddcc2211 ddcc 0 17e
2 c efbeadde 0df0feca 0 00000100 cafebeef cafe 0 17e
2 9 00100000 00000800 0 00008000 00081000 0008 0 17e
3 2 c 11223344 aabbccdd 0000c000 00000100 ddcc2211 ddcc 17e
3 1 f 00100000 00000800 00008000 0000f000 00081000 0008 17e
4 abcd0023 00401000 0 0 0 0023 00401000 0 040
5 00402468 0 0 0 0 0 00402468 0 040
6 00000246 0000001b 00500000 0 00000246 001b 00500000 0 040
6 00200202 ffff0008 c0001000 0 00200202 0008 c0001000 0 040
2 a 78563412 efcdab89 5 0000c000 89ab5678 89ab 0 17e
2 6 efbeadde 0df0feca 3 0000f000 cafebeef cafe 0 17e
1 fffffffc 1 f00d 0 fffffffc f00d 0 0 17e
4 00000010 fffffff0 0 0 0 0010 fffffff0 0 040
0 0 0 0 0 0 0 0 0 0

//--- tb/tb_sys_ctl.sv
`timescale 1ns/100ps

module tb_sys_ctl;
  import sys_ctl_pkg::*;

  localparam int fields  = 10;
  localparam int max_pat = 24;

  logic               or_int_vec;
  logic               arst_n;
  logic [num_int-1:0] int_vec;
  logic               hold_int;
  logic               mem_valid;
  logic               mem_ready;
  logic [addr_w-1:0]  mem_address;
  logic               mem_dp_valid;
  logic               mem_dp_ready;
  logic [addr_w-1:0]  mem_dp_read_data;
  logic               iretd;
  logic               ret_far;
  logic               ret_near;
  logic               iretd_pop_valid;
  logic [addr_w-1:0]  iretd_pop_data;
  jump_req_t          jump;
  logic               pending_int;
  logic               iretd_halt;
  flush_t             flush;
  fetch_redirect_t    fetch;
  arch_load_t         arch;

  logic [31:0] pat_mem [0:fields*max_pat-1];
  integer      seed;
  int          num_pat;
  int          cycle_cnt = 0;
  int          cycle_limit = 100;

  sys_ctl_top sys_ctl_top_i (
    .or_int_vec       (or_int_vec),
    .arst_n           (arst_n),
    .int_vec          (int_vec),
    .hold_int         (hold_int),
    .mem_valid        (mem_valid),
    .mem_ready        (mem_ready),
    .mem_address      (mem_address),
    .mem_dp_valid     (mem_dp_valid),
    .mem_dp_ready     (mem_dp_ready),
    .mem_dp_read_data (mem_dp_read_data),
    .iretd            (iretd),
    .ret_far          (ret_far),
    .ret_near         (ret_near),
    .iretd_pop_valid  (iretd_pop_valid),
    .iretd_pop_data   (iretd_pop_data),
    .jump             (jump),
    .pending_int      (pending_int),
    .iretd_halt       (iretd_halt),
    .flush            (flush),
    .fetch            (fetch),
    .arch             (arch)
  );

  initial or_int_vec = 1'b0;
  always #4 or_int_vec = ~or_int_vec;

  always @(posedge or_int_vec) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout: the DUT made no progress within %0d cycles", cycle_limit));
    end
  end

  //////////////////////////////////////////////////
  // checking

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string name);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED at %0d ns: %s is %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  function automatic int pick_delay();
    return {$random(seed)} % 4;
  endfunction

  task automatic check_redirect(input logic [31:0] addr, input logic [31:0] cs,
                                input logic [31:0] flags);
    check(32'(fetch.load), 32'd1, "fetch.load");
    check(fetch.address, addr, "fetch.address");
    check(32'(flush), 32'(flags[6:0]), "flush");
    check(32'(arch.load_cs), 32'(flags[8]), "arch.load_cs");
    if (flags[8]) begin
      check(32'(arch.cs), 32'(cs[15:0]), "arch.cs");
    end
  endtask

  //////////////////////////////////////////////////
  // memory model

  // ends at the falling edge inside the data cycle
  task automatic serve_read(input logic [31:0] addr_exp, input logic [31:0] word);
    int d;
    @(negedge or_int_vec);
    while (!mem_valid) @(negedge or_int_vec);
    check(mem_address, addr_exp, "mem_address");
    d = pick_delay();
    repeat (d) @(posedge or_int_vec);
    @(posedge or_int_vec);
    mem_ready <= 1'b1;
    @(posedge or_int_vec);
    mem_ready <= 1'b0;
    d = pick_delay();
    repeat (d) @(posedge or_int_vec);
    mem_dp_valid     <= 1'b1;
    mem_dp_read_data <= word;
    @(negedge or_int_vec);
    check(32'(mem_dp_ready), 32'd1, "mem_dp_ready");
  endtask

  task automatic service_int(input logic [31:0] entry, input logic [31:0] w0,
                             input logic [31:0] w1, input logic [31:0] eip,
                             input logic [31:0] cs, input logic [31:0] flags);
    serve_read(entry, w0);
    check(32'(fetch.load), 32'd0, "fetch.load");
    @(posedge or_int_vec);
    mem_dp_valid <= 1'b0;
    serve_read(entry + 32'd4, w1);
    check_redirect(eip, cs, flags);
    @(posedge or_int_vec);
    mem_dp_valid <= 1'b0;
    @(negedge or_int_vec);
    check(32'(fetch.load), 32'd0, "fetch.load");
  endtask

  //////////////////////////////////////////////////
  // scenarios

  task automatic run_jump(input int b);
    @(posedge or_int_vec);
    jump.load    <= 1'b1;
    jump.address <= pat_mem[b+1];
    jump.load_cs <= pat_mem[b+2][0];
    jump.cs      <= pat_mem[b+3][sel_w-1:0];
    @(posedge or_int_vec);
    jump <= '0;
    @(negedge or_int_vec);
    check_redirect(pat_mem[b+5], pat_mem[b+6], pat_mem[b+9]);
    check(32'(arch.load_eip), 32'd0, "arch.load_eip");
    @(negedge or_int_vec);
    check(32'(fetch.load), 32'd0, "fetch.load");
  endtask

  task automatic run_int(input int b);
    logic [num_int-1:0] mask;
    int hold;
    mask = '0;
    mask[pat_mem[b+1][vec_w-1:0]] = 1'b1;
    hold = int'(pat_mem[b+4]);
    @(negedge or_int_vec);
    check(32'(pending_int), 32'd0, "pending_int");
    @(posedge or_int_vec);
    hold_int <= (hold > 0);
    int_vec  <= mask;
    @(posedge or_int_vec);
    int_vec <= '0;
    @(negedge or_int_vec);
    check(32'(pending_int), 32'd1, "pending_int");
    // no request may leave while service is held off
    repeat (hold) begin
      check(32'(mem_valid), 32'd0, "mem_valid");
      @(negedge or_int_vec);
    end
    @(posedge or_int_vec);
    hold_int <= 1'b0;
    service_int(pat_mem[b+5], pat_mem[b+2], pat_mem[b+3], pat_mem[b+6], pat_mem[b+7],
                pat_mem[b+9]);
    check(32'(pending_int), 32'd0, "pending_int");
  endtask

  task automatic run_pair(input int b);
    logic [num_int-1:0] mask;
    mask = '0;
    mask[pat_mem[b+1][vec_w-1:0]] = 1'b1;
    mask[pat_mem[b+2][vec_w-1:0]] = 1'b1;
    @(posedge or_int_vec);
    int_vec <= mask;
    @(posedge or_int_vec);
    int_vec <= '0;
    @(negedge or_int_vec);
    check(32'(pending_int), 32'd1, "pending_int");
    service_int(pat_mem[b+5], pat_mem[b+3], pat_mem[b+4], pat_mem[b+7], pat_mem[b+8],
                pat_mem[b+9]);
    check(32'(pending_int), 32'd1, "pending_int");
    service_int(pat_mem[b+6], pat_mem[b+3], pat_mem[b+4], pat_mem[b+7], pat_mem[b+8],
                pat_mem[b+9]);
    check(32'(pending_int), 32'd0, "pending_int");
  endtask

  task automatic run_return(input int b);
    logic [31:0] kind;
    int n;
    int step;
    int d;
    kind = pat_mem[b];
    n = (kind == 6) ? 3 : (kind == 4) ? 2 : 1;
    @(posedge or_int_vec);
    iretd    <= (kind == 6);
    ret_far  <= (kind == 4);
    ret_near <= (kind == 5);
    @(posedge or_int_vec);
    iretd    <= 1'b0;
    ret_far  <= 1'b0;
    ret_near <= 1'b0;
    @(negedge or_int_vec);
    check(32'(iretd_halt), 32'd1, "iretd_halt");
    for (int i = 0; i < n; i++) begin
      // step 0 eflags, 1 cs, 2 eip
      step = 3 - n + i;
      d = pick_delay();
      repeat (d) begin
        @(posedge or_int_vec);
        iretd_pop_valid <= 1'b0;
        @(negedge or_int_vec);
        check(32'(iretd_halt), 32'd1, "iretd_halt");
        check(32'(flush.fetch), 32'd1, "flush.fetch");
      end
      @(posedge or_int_vec);
      iretd_pop_valid <= 1'b1;
      iretd_pop_data  <= pat_mem[b+1+i];
      @(negedge or_int_vec);
      check(32'(flush.fetch), 32'd1, "flush.fetch");
      check(32'(arch.load_eflags), 32'(step == 0), "arch.load_eflags");
      check(32'(arch.load_eip), 32'(step == 2), "arch.load_eip");
      if (step == 0) begin
        check(arch.eflags, pat_mem[b+5], "arch.eflags");
      end
      if (step == 1) begin
        check(32'(arch.load_cs), 32'd1, "arch.load_cs");
        check(32'(arch.cs), 32'(pat_mem[b+6][15:0]), "arch.cs");
      end
      if (step == 2) begin
        check_redirect(pat_mem[b+7], pat_mem[b+6], pat_mem[b+9]);
        check(arch.eip, pat_mem[b+7], "arch.eip");
      end else begin
        check(32'(fetch.load), 32'd0, "fetch.load");
      end
    end
    @(posedge or_int_vec);
    iretd_pop_valid <= 1'b0;
    @(negedge or_int_vec);
    check(32'(iretd_halt), 32'd0, "iretd_halt");
    check(32'(fetch.load), 32'd0, "fetch.load");
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int b;
    seed = 32'hfbea;
    arst_n           <= 1'b0;
    int_vec          <= '0;
    hold_int         <= 1'b0;
    mem_ready        <= 1'b0;
    mem_dp_valid     <= 1'b0;
    mem_dp_read_data <= '0;
    iretd            <= 1'b0;
    ret_far          <= 1'b0;
    ret_near         <= 1'b0;
    iretd_pop_valid  <= 1'b0;
    iretd_pop_data   <= '0;
    jump             <= '0;
    num_pat = 0;
    $readmemh("tb/sys_ctl_patterns.txt", pat_mem);
    while (num_pat < max_pat && pat_mem[num_pat*fields] != 32'd0) begin
      num_pat++;
    end
    cycle_limit = 40 * num_pat + 100;
    if (num_pat == 0) begin
      abort_run("no scenarios found in tb/sys_ctl_patterns.txt");
    end
    @(posedge or_int_vec);
    @(negedge or_int_vec);
    check(32'(mem_valid), 32'd0, "mem_valid");
    check(32'(mem_dp_ready), 32'd0, "mem_dp_ready");
    check(32'(iretd_halt), 32'd0, "iretd_halt");
    check(32'(pending_int), 32'd0, "pending_int");
    check(32'(fetch.load), 32'd0, "fetch.load");
    check(32'({arch.load_eflags, arch.load_cs, arch.load_eip}), 32'd0, "arch loads");
    check(32'(flush), 32'd0, "flush");
    @(posedge or_int_vec);
    arst_n <= 1'b1;
    for (int p = 0; p < num_pat; p++) begin
      b = p * fields;
      case (pat_mem[b])
        32'd1:   run_jump(b);
        32'd2:   run_int(b);
        32'd3:   run_pair(b);
        32'd4,
        32'd5,
        32'd6:   run_return(b);
        default: abort_run($sformatf("scenario %0d has an unknown kind code", p));
      endcase
      repeat (2) @(posedge or_int_vec);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog.f
src/sys_ctl_pkg.sv
src/int_pending.sv
src/idt_fetch.sv
src/sys_ctl_fsm.sv
src/redirect_merge.sv
src/sys_ctl_top.sv
tb/sys_ctl_asserts.sv
tb/tb_sys_ctl.sv
